// File: source/interconnect_consts.svh
/*
 * Interconnect constants: host command address, DRAM line width,
 * translation cache size, page number and device offset widths.
 */
`ifndef INTERCONNECT_CONSTS_SVH
`define INTERCONNECT_CONSTS_SVH

// physical address of the host command register
`define TOHOST_ADDR 32'h40008000

// one DRAM line holds four words
`define LINE_BITS 128

// translation cache size, power of two
`define TLB_ENTRIES 4

// sv32 page numbers
`define VPN_BITS 20
`define PPN_BITS 20

// device offset seen by PLIC, CLINT and framebuffer
`define OFFSET_MASK_BITS 27

`endif

// File: source/mem_map_pkg.sv
/*
 * Memory map types: addresses, words, DRAM lines, page numbers
 * and the region code held in the top address nibble.
 */
`default_nettype none
`include "interconnect_consts.svh"

package mem_map_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [`LINE_BITS-1:0] line_t;

    typedef logic [`VPN_BITS-1:0] vpn_t;
    typedef logic [`PPN_BITS-1:0] ppn_t;

    // top address nibble, other codes are unmapped
    typedef enum logic [3:0] {
        REGION_DRAM_LO = 4'h0,
        REGION_VIRTIO  = 4'h4,
        REGION_PLIC    = 4'h5,
        REGION_CLINT   = 4'h6,
        REGION_DRAM_HI = 4'h8
    } region_e;

    // virtio sub-device of the simple framebuffer
    localparam logic [3:0] VIRT_FB = 4'h5;

endpackage

`default_nettype wire

// File: source/mem_access_pkg.sv
/*
 * Access types: load/store width codes, host commands written
 * to the tohost register and the boot loader states.
 */
`default_nettype none

package mem_access_pkg;

    // funct3 of RISC-V loads and stores
    typedef enum logic [2:0] {
        F3_B  = 3'b000,
        F3_H  = 3'b001,
        F3_W  = 3'b010,
        F3_BU = 3'b100,
        F3_HU = 3'b101
    } funct3_e;

    // upper half of the tohost word
    typedef enum logic [15:0] {
        CMD_NONE       = 16'h0000,
        CMD_POWER_OFF  = 16'h0002,
        CMD_PRINT_CHAR = 16'h0101
    } host_cmd_e;

    typedef enum logic {
        BOOT_LOAD = 1'b0,
        BOOT_DONE = 1'b1
    } boot_state_e;

endpackage

`default_nettype wire

// File: source/tlb_cache.sv
/*
 * Direct-mapped translation cache. Combinational lookup of a VPN,
 * fill and flush take effect at the next clock edge.
 */
`timescale 1ns/1ps
`default_nettype none
`include "interconnect_consts.svh"

module tlb_cache #(
    parameter int ENTRIES = `TLB_ENTRIES
) (
    input  wire                CLK,
    input  wire                i_rst,
    input  wire                i_flush,
    input  wire                i_we,
    input  wire mem_map_pkg::vpn_t i_wvpn,
    input  wire mem_map_pkg::vpn_t i_lookup_vpn,
    input  wire mem_map_pkg::ppn_t i_wppn,
    output mem_map_pkg::ppn_t  o_ppn,
    output logic               o_hit
);
    import mem_map_pkg::*;

    // ENTRIES must be a power of two for the index split
    localparam int IDX_BITS = $clog2(ENTRIES);
    localparam int TAG_BITS = `VPN_BITS - IDX_BITS;

    logic [TAG_BITS-1:0] r_tag [ENTRIES];
    ppn_t                r_ppn [ENTRIES];
    logic [ENTRIES-1:0]  r_valid;

    logic [IDX_BITS-1:0] w_ridx;
    logic [TAG_BITS-1:0] w_rtag;
    logic [IDX_BITS-1:0] w_widx;
    logic [TAG_BITS-1:0] w_wtag;

    assign w_ridx = i_lookup_vpn[IDX_BITS-1:0];
    assign w_rtag = i_lookup_vpn[`VPN_BITS-1:IDX_BITS];
    assign w_widx = i_wvpn[IDX_BITS-1:0];
    assign w_wtag = i_wvpn[`VPN_BITS-1:IDX_BITS];

    assign o_ppn = r_ppn[w_ridx];
    assign o_hit = r_valid[w_ridx] && (r_tag[w_ridx] == w_rtag);

    // valid bits
    always_ff @(posedge CLK) begin
        if (i_rst || i_flush) begin
            r_valid <= '0;
        end else if (i_we) begin
            r_valid[w_widx] <= 1'b1;
        end
    end

    // tag and ppn storage
    always_ff @(posedge CLK) begin
        if (i_we) begin
            r_tag[w_widx] <= w_wtag;
            r_ppn[w_widx] <= i_wppn;
        end
    end

    // the fill agent never flushes and fills at once
    a_no_fill_on_flush: assert property (
        @(posedge CLK) disable iff (i_rst) !(i_we && i_flush)
    );

endmodule

`default_nettype wire

// File: source/addr_router.sv
/*
 * Address router: picks the translated or raw address, decodes the
 * region, drives device strobes and the DRAM port, muxes read data.
 */
`timescale 1ns/1ps
`default_nettype none
`include "interconnect_consts.svh"

module addr_router (
    input  wire                          CLK,
    input  wire                          i_rst,
    input  wire mem_map_pkg::addr_t      i_addr,
    input  wire mem_map_pkg::word_t      i_wdata,
    input  wire                          i_we,
    input  wire                          i_re,
    input  wire mem_access_pkg::funct3_e i_ctrl,
    input  wire [1:0]                    i_priv,
    input  wire                          i_satp_on,
    input  wire mem_map_pkg::ppn_t       i_tlb_ppn,
    input  wire                          i_tlb_hit,
    input  wire                          i_init_done,
    input  wire mem_map_pkg::addr_t      i_loader_addr,
    input  wire mem_map_pkg::word_t      i_loader_data,
    input  wire                          i_loader_we,
    input  wire mem_map_pkg::word_t      i_plic_rdata,
    input  wire mem_map_pkg::word_t      i_clint_rdata,
    input  wire mem_map_pkg::word_t      i_fb_rdata,
    input  wire mem_map_pkg::word_t      i_dram_word,
    output mem_map_pkg::addr_t           o_paddr,
    output logic                         o_busy,
    output logic                         o_plic_we,
    output logic                         o_plic_re,
    output logic                         o_clint_we,
    output logic                         o_fb_we,
    output mem_map_pkg::word_t           o_dev_wdata,
    output mem_map_pkg::addr_t           o_dev_offset,
    output mem_map_pkg::addr_t           o_dram_addr,
    output mem_map_pkg::word_t           o_dram_wdata,
    output logic                         o_dram_we,
    output logic                         o_dram_re,
    output mem_access_pkg::funct3_e      o_dram_ctrl,
    output mem_map_pkg::word_t           o_rdata
);
    import mem_map_pkg::*;
    import mem_access_pkg::*;

    localparam logic [1:0] PRIV_M = 2'b11;

    logic    w_paging;
    logic    w_cpu_we;
    logic    w_cpu_re;
    logic    w_is_dram;
    region_e w_region;
    region_e r_region;
    logic [3:0] r_virt;

    // sv32 translation outside machine mode
    assign w_paging = i_satp_on && (i_priv != PRIV_M);
    assign o_paddr  = w_paging ? {i_tlb_ppn, i_addr[11:0]} : i_addr;

    // miss is a level, the cpu retries until the fill agent loads the entry
    assign o_busy = !i_init_done || (w_paging && !i_tlb_hit && (i_we || i_re));

    assign w_cpu_we  = i_we && !o_busy;
    assign w_cpu_re  = i_re && !o_busy;
    assign w_region  = region_e'(o_paddr[31:28]);
    assign w_is_dram = (w_region == REGION_DRAM_LO) || (w_region == REGION_DRAM_HI);

    // device strobes
    assign o_plic_we    = w_cpu_we && (w_region == REGION_PLIC);
    assign o_plic_re    = w_cpu_re && (w_region == REGION_PLIC);
    assign o_clint_we   = w_cpu_we && (w_region == REGION_CLINT);
    assign o_fb_we      = w_cpu_we && (w_region == REGION_VIRTIO) && (o_paddr[27:24] == VIRT_FB);
    assign o_dev_wdata  = i_wdata;
    assign o_dev_offset = {{(32-`OFFSET_MASK_BITS){1'b0}}, o_paddr[`OFFSET_MASK_BITS-1:0]};

    // loader owns DRAM until boot is done
    assign o_dram_addr  = i_init_done ? o_paddr : i_loader_addr;
    assign o_dram_wdata = i_init_done ? i_wdata : i_loader_data;
    assign o_dram_we    = i_init_done ? (w_cpu_we && w_is_dram) : i_loader_we;
    assign o_dram_re    = i_init_done && w_cpu_re && w_is_dram;
    assign o_dram_ctrl  = i_init_done ? i_ctrl : F3_W;

    // region of the access whose data returns next cycle
    always_ff @(posedge CLK) begin
        if (i_rst) begin
            r_region <= REGION_DRAM_LO;
            r_virt   <= 4'h0;
        end else begin
            r_region <= w_region;
            r_virt   <= o_paddr[27:24];
        end
    end

    always_comb begin
        case (r_region)
            REGION_PLIC:    o_rdata = i_plic_rdata;
            REGION_CLINT:   o_rdata = i_clint_rdata;
            REGION_VIRTIO:  o_rdata = (r_virt == VIRT_FB) ? i_fb_rdata : '0;
            REGION_DRAM_LO: o_rdata = i_dram_word;
            REGION_DRAM_HI: o_rdata = i_dram_word;
            default:        o_rdata = '0;
        endcase
    end

    a_one_dev_strobe: assert property (
        @(posedge CLK) disable iff (i_rst)
        $onehot0({o_plic_we, o_plic_re, o_clint_we, o_fb_we})
    );

endmodule

`default_nettype wire

// File: source/load_aligner.sv
/*
 * DRAM load aligner: keeps the byte offset and width of the last
 * request and extracts the extended load word from the returned line.
 */
`timescale 1ns/1ps
`default_nettype none

module load_aligner (
    input  wire                          CLK,
    input  wire                          i_rst,
    input  wire                          i_capture,
    input  wire mem_map_pkg::addr_t      i_addr,
    input  wire mem_access_pkg::funct3_e i_ctrl,
    input  wire mem_map_pkg::line_t      i_line,
    output mem_map_pkg::word_t           o_word
);
    import mem_map_pkg::*;
    import mem_access_pkg::*;

    logic [3:0] r_off;
    funct3_e    r_ctrl;
    line_t      w_shifted;
    word_t      w_raw;

    always_ff @(posedge CLK) begin
        if (i_rst) begin
            r_off  <= 4'h0;
            r_ctrl <= F3_W;
        end else if (i_capture) begin
            r_off  <= i_addr[3:0];
            r_ctrl <= i_ctrl;
        end
    end

    // byte offset into the line
    assign w_shifted = i_line >> {r_off, 3'b000};
    assign w_raw     = w_shifted[31:0];

    always_comb begin
        case (r_ctrl)
            F3_B:    o_word = {{24{w_raw[7]}}, w_raw[7:0]};
            F3_BU:   o_word = {24'h0, w_raw[7:0]};
            F3_H:    o_word = {{16{w_raw[15]}}, w_raw[15:0]};
            F3_HU:   o_word = {16'h0, w_raw[15:0]};
            default: o_word = w_raw;
        endcase
    end

endmodule

`default_nettype wire

// File: source/tohost_unit.sv
/*
 * Host command register. Print-char gives a one-cycle character
 * strobe, power-off raises a sticky finish flag.
 */
`timescale 1ns/1ps
`default_nettype none
`include "interconnect_consts.svh"

module tohost_unit (
    input  wire                     CLK,
    input  wire                     i_rst,
    input  wire mem_map_pkg::addr_t i_paddr,
    input  wire mem_map_pkg::word_t i_wdata,
    input  wire                     i_we,
    output logic                    o_char_we,
    output logic [7:0]              o_char_data,
    output logic                    o_finish
);
    import mem_map_pkg::*;
    import mem_access_pkg::*;

    word_t     r_tohost;
    host_cmd_e w_cmd;
    logic      w_hit;

    assign w_cmd = host_cmd_e'(r_tohost[31:16]);
    assign w_hit = i_we && (i_paddr == `TOHOST_ADDR);

    always_ff @(posedge CLK) begin
        if (i_rst) begin
            r_tohost  <= '0;
            o_char_we <= 1'b0;
            o_finish  <= 1'b0;
        end else begin
            o_char_we <= (w_cmd == CMD_PRINT_CHAR);
            if (w_cmd == CMD_POWER_OFF) begin
                o_finish <= 1'b1;
            end
            // a new write wins over the self clear
            if (w_hit) begin
                r_tohost <= i_wdata;
            end else if (w_cmd == CMD_PRINT_CHAR) begin
                r_tohost <= '0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (w_cmd == CMD_PRINT_CHAR) begin
            o_char_data <= r_tohost[7:0];
        end
    end

endmodule

`default_nettype wire

// File: source/boot_loader_ctrl.sv
/*
 * Boot loader control: tracks load and done states and sums the
 * loader data into a checksum while loading.
 */
`timescale 1ns/1ps
`default_nettype none

module boot_loader_ctrl (
    input  wire                     CLK,
    input  wire                     i_rst,
    input  wire                     i_loader_we,
    input  wire mem_map_pkg::word_t i_loader_data,
    input  wire                     i_loader_done,
    output logic                    o_init_done,
    output mem_map_pkg::word_t      o_checksum
);
    import mem_map_pkg::*;
    import mem_access_pkg::*;

    boot_state_e r_state;

    always_ff @(posedge CLK) begin
        if (i_rst) begin
            r_state    <= BOOT_LOAD;
            o_checksum <= '0;
        end else if (r_state == BOOT_LOAD) begin
            // wraps at 32 bits
            if (i_loader_we) begin
                o_checksum <= o_checksum + i_loader_data;
            end
            if (i_loader_done) begin
                r_state <= BOOT_DONE;
            end
        end
    end

    assign o_init_done = (r_state == BOOT_DONE);

    // loader stays silent once boot is done
    a_no_load_after_done: assert property (
        @(posedge CLK) disable iff (i_rst)
        (r_state == BOOT_DONE) |-> !i_loader_we
    );

endmodule

`default_nettype wire

// File: source/soc_interconnect.sv
/*
 * Memory-side interconnect top: translation cache, router, load
 * aligner, host command unit and boot loader control.
 */
`timescale 1ns/1ps
`default_nettype none

module soc_interconnect (
    input  wire                          CLK,
    input  wire                          i_rst,
    // cpu data port
    input  wire mem_map_pkg::addr_t      i_addr,
    input  wire mem_map_pkg::word_t      i_wdata,
    input  wire                          i_we,
    input  wire                          i_re,
    input  wire mem_access_pkg::funct3_e i_ctrl,
    input  wire [1:0]                    i_priv,
    input  wire                          i_satp_on,
    output logic                         o_busy,
    output mem_map_pkg::word_t           o_rdata,
    // tlb fill
    input  wire                          i_tlb_we,
    input  wire                          i_tlb_flush,
    input  wire mem_map_pkg::vpn_t       i_tlb_vpn,
    input  wire mem_map_pkg::ppn_t       i_tlb_ppn,
    // devices
    output logic                         o_plic_we,
    output logic                         o_plic_re,
    output logic                         o_clint_we,
    output logic                         o_fb_we,
    output mem_map_pkg::word_t           o_dev_wdata,
    output mem_map_pkg::addr_t           o_dev_offset,
    input  wire mem_map_pkg::word_t      i_plic_rdata,
    input  wire mem_map_pkg::word_t      i_clint_rdata,
    input  wire mem_map_pkg::word_t      i_fb_rdata,
    // dram
    output mem_map_pkg::addr_t           o_dram_addr,
    output mem_map_pkg::word_t           o_dram_wdata,
    output logic                         o_dram_we,
    output logic                         o_dram_re,
    output mem_access_pkg::funct3_e      o_dram_ctrl,
    input  wire mem_map_pkg::line_t      i_dram_line,
    // loader
    input  wire mem_map_pkg::addr_t      i_loader_addr,
    input  wire mem_map_pkg::word_t      i_loader_data,
    input  wire                          i_loader_we,
    input  wire                          i_loader_done,
    // status
    output logic                         o_char_we,
    output logic [7:0]                   o_char_data,
    output logic                         o_finish,
    output logic                         o_init_done,
    output mem_map_pkg::word_t           o_checksum
);
    import mem_map_pkg::*;

    ppn_t  w_lookup_ppn;
    logic  w_tlb_hit;
    addr_t w_paddr;
    word_t w_dram_word;
    logic  w_capture;
    logic  w_host_we;

    assign w_capture = o_dram_re || o_dram_we;
    assign w_host_we = i_we && !o_busy;

    tlb_cache u_tlb (
        .CLK          (CLK),
        .i_rst        (i_rst),
        .i_flush      (i_tlb_flush),
        .i_we         (i_tlb_we),
        .i_wvpn       (i_tlb_vpn),
        .i_lookup_vpn (i_addr[31:12]),
        .i_wppn       (i_tlb_ppn),
        .o_ppn        (w_lookup_ppn),
        .o_hit        (w_tlb_hit)
    );

    addr_router u_router (
        .CLK (CLK), .i_rst (i_rst),
        .i_addr (i_addr), .i_wdata (i_wdata), .i_we (i_we), .i_re (i_re), .i_ctrl (i_ctrl),
        .i_priv (i_priv), .i_satp_on (i_satp_on),
        .i_tlb_ppn (w_lookup_ppn), .i_tlb_hit (w_tlb_hit),
        .i_init_done (o_init_done),
        .i_loader_addr (i_loader_addr), .i_loader_data (i_loader_data),
        .i_loader_we (i_loader_we),
        .i_plic_rdata (i_plic_rdata), .i_clint_rdata (i_clint_rdata),
        .i_fb_rdata (i_fb_rdata), .i_dram_word (w_dram_word),
        .o_paddr (w_paddr), .o_busy (o_busy),
        .o_plic_we (o_plic_we), .o_plic_re (o_plic_re),
        .o_clint_we (o_clint_we), .o_fb_we (o_fb_we),
        .o_dev_wdata (o_dev_wdata), .o_dev_offset (o_dev_offset),
        .o_dram_addr (o_dram_addr), .o_dram_wdata (o_dram_wdata),
        .o_dram_we (o_dram_we), .o_dram_re (o_dram_re), .o_dram_ctrl (o_dram_ctrl),
        .o_rdata (o_rdata)
    );

    load_aligner u_align (
        .CLK       (CLK),
        .i_rst     (i_rst),
        .i_capture (w_capture),
        .i_addr    (o_dram_addr),
        .i_ctrl    (o_dram_ctrl),
        .i_line    (i_dram_line),
        .o_word    (w_dram_word)
    );

    tohost_unit u_tohost (
        .CLK         (CLK),
        .i_rst       (i_rst),
        .i_paddr     (w_paddr),
        .i_wdata     (i_wdata),
        .i_we        (w_host_we),
        .o_char_we   (o_char_we),
        .o_char_data (o_char_data),
        .o_finish    (o_finish)
    );

    boot_loader_ctrl u_boot (
        .CLK           (CLK),
        .i_rst         (i_rst),
        .i_loader_we   (i_loader_we),
        .i_loader_data (i_loader_data),
        .i_loader_done (i_loader_done),
        .o_init_done   (o_init_done),
        .o_checksum    (o_checksum)
    );

endmodule

`default_nettype wire

// File: bench/tb_soc_interconnect.sv
/*
 * Interconnect testbench: plays the golden vectors against the top
 * level with a DRAM line model and fixed device read data.
 */
`timescale 1ns/1ps
`default_nettype none
`include "interconnect_consts.svh"

module tb_soc_interconnect;
    import mem_map_pkg::*;
    import mem_access_pkg::*;

    localparam int    RESET_CYCLES = 10;
    localparam int    MAX_VECTORS  = 64;
    localparam addr_t OFFSET_MASK  = (32'h1 << `OFFSET_MASK_BITS) - 32'h1;
    localparam word_t PLIC_DATA    = 32'h11223344;
    localparam word_t CLINT_DATA   = 32'h55667788;
    localparam word_t FB_DATA      = 32'h99AABBCC;

    // golden operation codes
    localparam logic [7:0] OP_LOADER_WR   = 8'h01;
    localparam logic [7:0] OP_LOADER_DONE = 8'h02;
    localparam logic [7:0] OP_TLB_FILL    = 8'h03;
    localparam logic [7:0] OP_TLB_FLUSH   = 8'h04;
    localparam logic [7:0] OP_CPU_WR      = 8'h05;
    localparam logic [7:0] OP_CPU_RD      = 8'h06;
    localparam logic [7:0] OP_HOST        = 8'h07;
    localparam logic [7:0] OP_BUSY        = 8'h08;

    logic       CLK = 1'b0;
    logic       i_rst;
    addr_t      i_addr;
    word_t      i_wdata;
    logic       i_we;
    logic       i_re;
    funct3_e    i_ctrl;
    logic [1:0] i_priv;
    logic       i_satp_on;
    logic       o_busy;
    word_t      o_rdata;
    logic       i_tlb_we;
    logic       i_tlb_flush;
    vpn_t       i_tlb_vpn;
    ppn_t       i_tlb_ppn;
    logic       o_plic_we;
    logic       o_plic_re;
    logic       o_clint_we;
    logic       o_fb_we;
    word_t      o_dev_wdata;
    addr_t      o_dev_offset;
    word_t      i_plic_rdata;
    word_t      i_clint_rdata;
    word_t      i_fb_rdata;
    addr_t      o_dram_addr;
    word_t      o_dram_wdata;
    logic       o_dram_we;
    logic       o_dram_re;
    funct3_e    o_dram_ctrl;
    line_t      i_dram_line;
    addr_t      i_loader_addr;
    word_t      i_loader_data;
    logic       i_loader_we;
    logic       i_loader_done;
    logic       o_char_we;
    logic [7:0] o_char_data;
    logic       o_finish;
    logic       o_init_done;
    word_t      o_checksum;

    line_t        dram [16];
    logic [135:0] vec [MAX_VECTORS];
    int           n_vec;
    logic         loaded = 1'b0;
    logic         dram_rd_q;
    logic         dram_wr_q;
    addr_t        dram_addr_q;
    word_t        dram_wdata_q;

    soc_interconnect UUT (.*);

    always #10 CLK = ~CLK;

    // request sampled mid-cycle and applied just after the next edge
    always @(negedge CLK) begin
        dram_rd_q    <= o_dram_re;
        dram_wr_q    <= o_dram_we;
        dram_addr_q  <= o_dram_addr;
        dram_wdata_q <= o_dram_wdata;
    end

    always @(posedge CLK) begin
        #1;
        if (dram_wr_q) begin
            dram[dram_addr_q[7:4]][{dram_addr_q[3:2], 5'b00000} +: 32] = dram_wdata_q;
        end
        if (dram_rd_q) begin
            i_dram_line = dram[dram_addr_q[7:4]];
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_ctrl(input string name, input funct3_e got, input funct3_e exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s got 0x%02h expected 0x%02h", name, got, exp));
        end
    endtask

    // mask bits from msb are plic_we plic_re clint_we fb_we dram_we dram_re
    task automatic check_strobes(input logic [5:0] m);
        check_flag("o_plic_we", o_plic_we, m[5]);
        check_flag("o_plic_re", o_plic_re, m[4]);
        check_flag("o_clint_we", o_clint_we, m[3]);
        check_flag("o_fb_we", o_fb_we, m[2]);
        check_flag("o_dram_we", o_dram_we, m[1]);
        check_flag("o_dram_re", o_dram_re, m[0]);
    endtask

    task automatic drive_idle();
        i_addr        = '0;
        i_wdata       = '0;
        i_we          = 1'b0;
        i_re          = 1'b0;
        i_ctrl        = F3_W;
        i_priv        = 2'b11;
        i_satp_on     = 1'b0;
        i_tlb_we      = 1'b0;
        i_tlb_flush   = 1'b0;
        i_tlb_vpn     = '0;
        i_tlb_ppn     = '0;
        i_loader_addr = '0;
        i_loader_data = '0;
        i_loader_we   = 1'b0;
        i_loader_done = 1'b0;
    endtask

    task automatic apply_ctl(input word_t c);
        i_priv    = c[13:12];
        i_satp_on = c[4];
        i_ctrl    = funct3_e'(c[2:0]);
    endtask

    task automatic next_edge();
        @(posedge CLK);
        #1;
    endtask

    task automatic close_access();
        next_edge();
        drive_idle();
    endtask

    task automatic run_vector(input logic [135:0] v);
        logic [7:0] op;
        addr_t      a;
        word_t      b;
        word_t      c;
        word_t      e;
        op = v[135:128];
        a  = v[127:96];
        b  = v[95:64];
        c  = v[63:32];
        e  = v[31:0];
        case (op)
            OP_LOADER_WR: begin
                i_loader_we   = 1'b1;
                i_loader_addr = a;
                i_loader_data = b;
                @(negedge CLK);
                check_flag("o_dram_we", o_dram_we, 1'b1);
                check_addr("o_dram_addr", o_dram_addr, a);
                check_word("o_dram_wdata", o_dram_wdata, b);
                check_ctrl("o_dram_ctrl", o_dram_ctrl, F3_W);
                close_access();
            end
            OP_LOADER_DONE: begin
                i_loader_done = 1'b1;
                @(negedge CLK);
                check_word("o_checksum", o_checksum, e);
                check_flag("o_init_done", o_init_done, 1'b0);
                close_access();
                @(negedge CLK);
                check_flag("o_init_done", o_init_done, 1'b1);
                next_edge();
            end
            OP_TLB_FILL: begin
                i_tlb_we  = 1'b1;
                i_tlb_vpn = a[19:0];
                i_tlb_ppn = b[19:0];
                close_access();
            end
            OP_TLB_FLUSH: begin
                i_tlb_flush = 1'b1;
                close_access();
            end
            OP_CPU_WR: begin
                i_we    = 1'b1;
                i_addr  = a;
                i_wdata = b;
                apply_ctl(c);
                @(negedge CLK);
                check_flag("o_busy", o_busy, 1'b0);
                check_strobes(c[29:24]);
                check_addr("o_dev_offset", o_dev_offset, e & OFFSET_MASK);
                check_word("o_dev_wdata", o_dev_wdata, b);
                if (c[25]) begin
                    check_addr("o_dram_addr", o_dram_addr, e);
                    check_word("o_dram_wdata", o_dram_wdata, b);
                    check_ctrl("o_dram_ctrl", o_dram_ctrl, funct3_e'(c[2:0]));
                end
                close_access();
            end
            OP_CPU_RD: begin
                i_re   = 1'b1;
                i_addr = a;
                apply_ctl(c);
                @(negedge CLK);
                check_flag("o_busy", o_busy, 1'b0);
                check_strobes(c[29:24]);
                check_addr("o_dev_offset", o_dev_offset, b & OFFSET_MASK);
                if (c[24]) begin
                    check_addr("o_dram_addr", o_dram_addr, b);
                    check_ctrl("o_dram_ctrl", o_dram_ctrl, funct3_e'(c[2:0]));
                end
                close_access();
                // data of the read arrives in the following cycle
                @(negedge CLK);
                check_word("o_rdata", o_rdata, e);
                next_edge();
            end
            OP_HOST: begin
                i_we    = 1'b1;
                i_addr  = a;
                i_wdata = b;
                apply_ctl(c);
                @(negedge CLK);
                check_flag("o_busy", o_busy, 1'b0);
                close_access();
                @(negedge CLK);
                check_flag("o_char_we", o_char_we, 1'b0);
                if (e[12]) begin
                    check_flag("o_finish", o_finish, 1'b0);
                end
                next_edge();
                @(negedge CLK);
                check_flag("o_char_we", o_char_we, e[8]);
                if (e[8]) begin
                    check_byte("o_char_data", o_char_data, e[7:0]);
                end
                check_flag("o_finish", o_finish, e[12]);
                next_edge();
                @(negedge CLK);
                check_flag("o_char_we", o_char_we, 1'b0);
                check_flag("o_finish", o_finish, e[12]);
                next_edge();
            end
            OP_BUSY: begin
                i_re   = 1'b1;
                i_addr = a;
                apply_ctl(c);
                @(negedge CLK);
                check_flag("o_busy", o_busy, 1'b1);
                check_strobes(6'b000000);
                close_access();
            end
            default: begin
                abort_run($sformatf("unknown operation code %02h in golden file", op));
            end
        endcase
    endtask

    // watchdog sized from the vector count
    initial begin
        wait (loaded === 1'b1);
        repeat (n_vec * 10 + RESET_CYCLES) @(posedge CLK);
        abort_run($sformatf("timeout after %0d cycles, vectors did not complete",
                            n_vec * 10 + RESET_CYCLES));
    end

    initial begin
        drive_idle();
        i_rst         = 1'b1;
        i_plic_rdata  = PLIC_DATA;
        i_clint_rdata = CLINT_DATA;
        i_fb_rdata    = FB_DATA;
        i_dram_line   = '0;
        dram_rd_q     = 1'b0;
        dram_wr_q     = 1'b0;
        dram_addr_q   = '0;
        dram_wdata_q  = '0;
        // fill pattern tied to line and word index
        for (int i = 0; i < 16; i++) begin
            for (int w = 0; w < 4; w++) begin
                dram[i][w*32 +: 32] = 32'hD000_0000 + 32'(i * 256 + w);
            end
        end
        for (int k = 0; k < MAX_VECTORS; k++) begin
            vec[k] = '1;
        end
        $readmemh("bench/golden_vectors.txt", vec);
        n_vec = 0;
        while (n_vec < MAX_VECTORS && vec[n_vec][135:128] != 8'hFF) begin
            n_vec++;
        end
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        i_rst = 1'b0;
        for (int k = 0; k < n_vec; k++) begin
            run_vector(vec[k]);
        end
        if (n_vec > 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            abort_run("golden file holds no vectors");
        end
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+source
source/mem_map_pkg.sv
source/mem_access_pkg.sv
source/tlb_cache.sv
source/addr_router.sv
source/load_aligner.sv
source/tohost_unit.sv
source/boot_loader_ctrl.sv
source/soc_interconnect.sv
bench/tb_soc_interconnect.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_soc_interconnect
FILELIST  = sources.f
OBJDIR    = obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q -F '*** PASSED ***'

clean:
	rm -rf $(OBJDIR)

// File: bench/golden_vectors.txt
// op_addr_b_ctl_exp, ctl = strobes[29:24] priv[13:12] satp[4] funct3[2:0]
// 01 ldr wr, 02 ldr done, 03 tlb fill, 04 flush, 05 wr (b data, exp paddr), 06 rd (b paddr), 07 tohost, 08 busy
08_80000000_00000000_00003002_00000000 // read before boot
01_80000000_F0000000_00000000_00000000
01_80000004_20000000_00000000_00000000
01_80000010_12345678_00000000_00000000
01_80000014_CAFEF00D_00000000_00000000
02_00000000_00000000_00000000_ED334685 // wrapped sum
05_80000020_80FF7F01_02003002_80000020
06_80000020_80000020_01003000_00000001 // lb
06_80000022_80000022_01003000_FFFFFFFF
06_80000023_80000023_01003004_00000080 // lbu
06_80000022_80000022_01003001_FFFF80FF // lh
06_80000022_80000022_01003005_000080FF // lhu
06_80000020_80000020_01003002_80FF7F01
06_80000014_80000014_01003002_CAFEF00D
06_00000011_00000011_01003004_00000056 // low dram window
05_50001004_A5A5A5A5_20003002_50001004 // plic
05_6000BFF8_00000001_08003002_6000BFF8 // clint
05_45000100_00FF00FF_04003002_45000100 // framebuffer
05_43000000_DEADDEAD_00003002_43000000 // other virtio device
06_50000004_50000004_10003002_11223344
06_6000BFF8_6000BFF8_00003002_55667788
06_45000000_45000000_00003002_99AABBCC
03_00000012_00080003_00000000_00000000
05_00012040_0BADBEEF_02000012_80003040 // user mode, paged
06_00012040_80003040_01001012_0BADBEEF // supervisor mode, paged
03_00000400_00050000_00000000_00000000
05_00400010_5A5A0001_20000012_50000010
08_00099000_00000000_00000012_00000000 // empty entry
08_00016000_00000000_00000012_00000000 // tag mismatch
06_80000020_80000020_01003012_80FF7F01 // machine mode bypass
04_00000000_00000000_00000000_00000000
08_00012040_00000000_00000012_00000000
07_40008000_01010041_00003002_00000141 // print 'A'
07_40008000_00020000_00003002_00001000 // power off
